//--- verilog/lsu_pkg.sv
// shared types and constants for the load/store unit
// imported by every RTL module and by the testbench

package lsu_pkg;

    // ========================================
    // sizes and address map
    // ========================================
    localparam int XLEN      = 32;
    localparam int NUM_LANES = 4;

    localparam logic [XLEN-1:0] DMEM_BASE = 32'h0001_0000;
    localparam int              DMEM_WORDS = 256;
    localparam int              DMEM_AW    = 8;

    localparam logic [XLEN-1:0] UART_ADDR    = 32'h0002_0000;
    localparam logic [XLEN-1:0] COUNTER_ADDR = 32'h0002_0004;

    // short bit time keeps simulation small
    localparam int CLKS_PER_BIT = 8;

    // ========================================
    // opcodes and states
    // ========================================
    // encoding fixed so pattern records can use hex digits
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // ========================================
    // request and response
    // ========================================
    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
    } load_rsp_t;

endpackage

//--- verilog/store_align.sv
// store decode: lane enables, lane data and the uart strobe
// purely combinational, also supplies the word index for reads

`timescale 1ns/1ns

module store_align import lsu_pkg::*; (
    input  mem_req_t               req,
    output logic [NUM_LANES-1:0]   lane_we,
    output logic [XLEN-1:0]        lane_wdata,
    output logic [DMEM_AW-1:0]     word_idx,
    output logic                   uart_we,
    output logic [7:0]             uart_data
);

    logic [1:0]           offset;
    logic [XLEN-1:0]      rel_addr;
    logic                 in_dmem;
    logic                 is_store;
    logic [NUM_LANES-1:0] lane_mask;

    assign offset   = req.addr[1:0];
    assign rel_addr = req.addr - DMEM_BASE;
    // wraps for addresses below the base, so one compare covers both ends
    assign in_dmem  = rel_addr < XLEN'(NUM_LANES * DMEM_WORDS);
    assign word_idx = rel_addr[DMEM_AW+1:2];

    assign is_store = req.valid &&
                      (req.op == MEM_SB || req.op == MEM_SH || req.op == MEM_SW);

    always_comb begin
        case (req.op)
            MEM_SW:  lane_mask = '1;
            // halfword at offset 3 would straddle words
            MEM_SH:  lane_mask = (offset == 2'd3) ? '0 : NUM_LANES'(2'b11) << offset;
            MEM_SB:  lane_mask = NUM_LANES'(1'b1) << offset;
            default: lane_mask = '0;
        endcase
    end

    assign lane_we = (is_store && in_dmem) ? lane_mask : '0;

    // only the enabled lanes matter, upper bytes may carry junk
    assign lane_wdata = (req.op == MEM_SW) ? req.wdata : req.wdata << {offset, 3'b000};

    assign uart_we   = is_store && (req.addr == UART_ADDR);
    assign uart_data = req.wdata[7:0];

endmodule

//--- verilog/byte_bank_ram.sv
// data memory as four byte-wide banks
// byte-masked synchronous write, registered read of the whole word

`timescale 1ns/1ns

module byte_bank_ram import lsu_pkg::*; (
    input  logic                 clk,
    input  logic [NUM_LANES-1:0] lane_we,
    input  logic [XLEN-1:0]      lane_wdata,
    input  logic [DMEM_AW-1:0]   word_idx,
    output logic [XLEN-1:0]      rd_data
);

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        logic [7:0] bank [DMEM_WORDS];
        logic [7:0] rd_byte;

        always_ff @(posedge clk) begin
            if (lane_we[g]) begin
                bank[word_idx] <= lane_wdata[8*g +: 8];
            end
            // read old data on a same-index write
            rd_byte <= bank[word_idx];
        end

        assign rd_data[8*g +: 8] = rd_byte;
    end

endmodule

//--- verilog/load_return.sv
// load return path with the cycle counter
// registers each accepted load and formats the bank data one cycle later

`timescale 1ns/1ns

module load_return import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  mem_req_t        req,
    input  logic [XLEN-1:0] rd_data,
    output load_rsp_t       rsp
);

    logic            is_load;
    logic [XLEN-1:0] cycle_cnt;
    logic            ld_valid;
    mem_op_e         ld_op;
    logic [1:0]      ld_off;
    logic            ld_cnt_sel;
    logic [XLEN-1:0] ld_cnt;
    logic [XLEN-1:0] lanes;
    logic [15:0]     half;
    logic [XLEN-1:0] mem_data;

    assign is_load = req.valid && (req.op == MEM_LB || req.op == MEM_LH ||
                     req.op == MEM_LW || req.op == MEM_LBU || req.op == MEM_LHU);

    // free-running counter, mapped at COUNTER_ADDR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            ld_valid  <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            ld_valid  <= is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            ld_op      <= req.op;
            ld_off     <= req.addr[1:0];
            ld_cnt_sel <= (req.addr == COUNTER_ADDR);
            ld_cnt     <= cycle_cnt;
        end
    end

    // ========================================
    // lane extract and extend
    // ========================================
    always_comb begin
        lanes = rd_data >> {ld_off, 3'b000};
        // halfword at offset 3 falls back to lanes 1:0
        half  = (ld_off == 2'd3) ? rd_data[15:0] : lanes[15:0];
        case (ld_op)
            MEM_LB:  mem_data = {{(XLEN-8){lanes[7]}}, lanes[7:0]};
            MEM_LBU: mem_data = {{(XLEN-8){1'b0}}, lanes[7:0]};
            MEM_LH:  mem_data = {{(XLEN-16){half[15]}}, half};
            MEM_LHU: mem_data = {{(XLEN-16){1'b0}}, half};
            default: mem_data = rd_data;
        endcase
    end

    always_comb begin
        rsp.valid = ld_valid;
        rsp.data  = ld_cnt_sel ? ld_cnt : mem_data;
    end

endmodule

//--- verilog/baud_timer.sv
// bit timer for the uart, one tick every CLKS_PER_BIT clocks
// bit_start holds the count at reload

`timescale 1ns/1ns

module baud_timer import lsu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic bit_start,
    output logic bit_tick
);

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] tick_cnt_t;

    tick_cnt_t cnt;

    assign bit_tick = (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= tick_cnt_t'(CLKS_PER_BIT - 1);
        end else if (bit_start || bit_tick) begin
            cnt <= tick_cnt_t'(CLKS_PER_BIT - 1);
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- verilog/uart_tx.sv
// uart transmitter, 8N1, lsb first
// a strobe while idle starts a frame; strobes during a frame are dropped

`timescale 1ns/1ns

module uart_tx_fsm import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_we,
    input  logic [7:0] uart_data,
    output logic       uart_tx
);

    uart_state_e state;
    logic [2:0]  bit_idx;
    logic [7:0]  shift_reg;
    logic        busy;
    logic        accept;
    logic        bit_start;
    logic        bit_tick;

    assign busy   = (state != UART_IDLE);
    assign accept = uart_we && !busy;

    // timer sits reloaded until a frame begins
    assign bit_start = !busy;

    baud_timer u_baud_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .bit_start (bit_start),
        .bit_tick  (bit_tick)
    );

    // ========================================
    // frame state machine
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            bit_idx <= 3'd0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                UART_IDLE: begin
                    if (accept) begin
                        state   <= UART_START;
                        uart_tx <= 1'b0;
                    end
                end
                UART_START: begin
                    if (bit_tick) begin
                        state   <= UART_DATA;
                        bit_idx <= 3'd0;
                        uart_tx <= shift_reg[0];
                    end
                end
                UART_DATA: begin
                    if (bit_tick) begin
                        if (bit_idx == 3'd7) begin
                            state   <= UART_STOP;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            uart_tx <= shift_reg[1];
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_tick) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // data shifter, bit 0 is the one on the line
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= uart_data;
        end else if (bit_tick && state == UART_DATA) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- verilog/rv_lsu_top.sv
// load/store unit top: store decode, byte banks, load return, uart
// one request per cycle, load data comes back the following cycle

`timescale 1ns/1ns

module rv_lsu_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  req,
    output load_rsp_t rsp,
    output logic      uart_tx
);

    logic [NUM_LANES-1:0] lane_we;
    logic [XLEN-1:0]      lane_wdata;
    logic [DMEM_AW-1:0]   word_idx;
    logic                 uart_we;
    logic [7:0]           uart_data;
    logic [XLEN-1:0]      rd_data;

    store_align u_store_align (
        .req        (req),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .word_idx   (word_idx),
        .uart_we    (uart_we),
        .uart_data  (uart_data)
    );

    byte_bank_ram u_dmem (
        .clk        (clk),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .word_idx   (word_idx),
        .rd_data    (rd_data)
    );

    load_return u_load_return (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .rd_data (rd_data),
        .rsp     (rsp)
    );

    uart_tx_fsm u_uart (
        .clk       (clk),
        .rst_n     (rst_n),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .uart_tx   (uart_tx)
    );

endmodule

//--- tb/tb_rv_lsu.sv
// self-checking testbench for the load/store unit
// replays request records from tb/lsu_patterns.mem, checks load data and the uart line

`timescale 1ns/1ns

module tb_rv_lsu import lsu_pkg::*; ();

    typedef enum logic [3:0] {
        K_END     = 4'd0,
        K_REQ     = 4'd1,
        K_LOAD    = 4'd2,
        K_CNT_REF = 4'd3,
        K_CNT_GAP = 4'd4,
        K_UART    = 4'd5,
        K_QUIET   = 4'd6
    } rec_kind_e;

    typedef struct packed {
        logic [7:0]      group;
        rec_kind_e       kind;
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] expected;
    } pattern_t;

    logic      clk = 1'b0;
    logic      rst_n;
    mem_req_t  req;
    load_rsp_t rsp;
    logic      uart_tx;

    logic [111:0] patterns [64];

    // two-deep pipeline of pending checks, slot2 is due at this edge
    rec_kind_e       slot1_kind;
    rec_kind_e       slot2_kind;
    logic [XLEN-1:0] slot1_exp;
    logic [XLEN-1:0] slot2_exp;
    logic [XLEN-1:0] cnt_ref;

    int group_errs;
    int tests_passed;
    int tests_failed;

    always #10 clk = ~clk;

    rv_lsu_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .rsp     (rsp),
        .uart_tx (uart_tx)
    );

    task automatic report_value(input string what, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        group_errs++;
    endtask

    task automatic check_slot();
        logic            is_load;
        logic [XLEN-1:0] gap;
        is_load = slot2_kind inside {K_LOAD, K_CNT_REF, K_CNT_GAP};
        if (rsp.valid !== is_load) report_value("rsp.valid", XLEN'(rsp.valid), XLEN'(is_load));
        case (slot2_kind)
            K_LOAD: begin
                if (rsp.data !== slot2_exp) report_value("load data", rsp.data, slot2_exp);
            end
            K_CNT_REF: cnt_ref = rsp.data;
            K_CNT_GAP: begin
                gap = rsp.data - cnt_ref;
                if (gap !== slot2_exp) report_value("counter gap", gap, slot2_exp);
            end
            default: ;
        endcase
    endtask

    // one clock: resolve the due check, then drive the next request
    task automatic advance(input rec_kind_e kind, input mem_req_t r, input logic [XLEN-1:0] exp);
        @(posedge clk);
        check_slot();
        slot2_kind = slot1_kind;
        slot2_exp  = slot1_exp;
        slot1_kind = kind;
        slot1_exp  = exp;
        req <= r;
    endtask

    task automatic idle_cycle();
        advance(K_REQ, '0, '0);
    endtask

    // ========================================
    // uart line checks
    // ========================================
    task automatic check_uart_frame(input logic [7:0] exp_byte);
        int wait_cnt;
        int i;
        wait_cnt = 0;
        idle_cycle();
        while (uart_tx !== 1'b0 && wait_cnt < 4 * CLKS_PER_BIT) begin
            idle_cycle();
            wait_cnt++;
        end
        if (uart_tx !== 1'b0) begin
            $display("Timed out waiting for the UART start bit at %0t", $time);
            group_errs++;
        end else begin
            // move to mid-bit
            repeat (CLKS_PER_BIT / 2) idle_cycle();
            if (uart_tx !== 1'b0) report_value("uart start bit", XLEN'(uart_tx), '0);
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) idle_cycle();
                if (uart_tx !== exp_byte[i]) begin
                    report_value("uart data bit", XLEN'(uart_tx), XLEN'(exp_byte[i]));
                end
            end
            repeat (CLKS_PER_BIT) idle_cycle();
            if (uart_tx !== 1'b1) report_value("uart stop bit", XLEN'(uart_tx), 32'd1);
            // let the stop bit finish before the next strobe
            repeat (CLKS_PER_BIT) idle_cycle();
        end
    endtask

    task automatic check_quiet_line();
        int i;
        for (i = 0; i < 2 * CLKS_PER_BIT; i++) begin
            idle_cycle();
            if (uart_tx !== 1'b1) report_value("idle uart line", XLEN'(uart_tx), 32'd1);
        end
    endtask

    task automatic finish_group(input logic [7:0] group);
        // drain the two pending check slots
        idle_cycle();
        idle_cycle();
        if (group_errs == 0) begin
            $display("test %0d passed", group);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", group, group_errs);
            tests_failed++;
        end
        group_errs = 0;
    endtask

    // ========================================
    // record replay
    // ========================================
    initial begin
        pattern_t   rec;
        mem_req_t   r;
        int         idx;
        logic [7:0] cur_group;
        rst_n <= 1'b0;
        req   <= '0;
        slot1_kind   = K_REQ;
        slot2_kind   = K_REQ;
        slot1_exp    = '0;
        slot2_exp    = '0;
        cnt_ref      = '0;
        group_errs   = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("tb/lsu_patterns.mem", patterns);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        cur_group = 8'd0;
        idx = 0;
        rec = patterns[0];
        while (idx < 64 && rec.kind != K_END) begin
            if (rec.group != cur_group) begin
                if (cur_group != 8'd0) finish_group(cur_group);
                cur_group = rec.group;
            end
            r.valid = (rec.op != MEM_NOP);
            r.op    = rec.op;
            r.addr  = rec.addr;
            r.wdata = rec.wdata;
            advance(rec.kind, r, rec.expected);
            if (rec.kind == K_UART) begin
                check_uart_frame(rec.expected[7:0]);
            end else if (rec.kind == K_QUIET) begin
                check_quiet_line();
            end
            idx++;
            if (idx < 64) rec = patterns[idx];
        end
        if (cur_group != 8'd0) finish_group(cur_group);

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb/lsu_patterns.mem
// columns: group _ kind _ opcode _ address _ write data _ expected, all hex
// kind 1 request, 2 load check, 3 counter base, 4 counter gap, 5 uart frame, 6 quiet line
01_1_8_00010000_11223344_00000000
01_1_8_00010004_a5a5f00f_00000000
01_1_8_000103fc_deadbeef_00000000
01_2_3_00010000_00000000_11223344
01_2_3_00010004_00000000_a5a5f00f
01_2_3_000103fc_00000000_deadbeef
02_1_8_00010010_00000000_00000000
02_1_6_00010010_123456aa_00000000
02_1_6_00010011_000000bb_00000000
02_1_6_00010012_000000cc_00000000
02_1_6_00010013_000000dd_00000000
02_2_3_00010010_00000000_ddccbbaa
02_1_7_00010010_00001111_00000000
02_1_7_00010012_00002222_00000000
02_1_7_00010011_00003333_00000000
02_1_7_00010013_00004444_00000000
02_2_3_00010010_00000000_22333311
03_1_8_00010020_80c3f281_00000000
03_2_1_00010020_00000000_ffffff81
03_2_1_00010021_00000000_fffffff2
03_2_1_00010022_00000000_ffffffc3
03_2_1_00010023_00000000_ffffff80
03_2_4_00010020_00000000_00000081
03_2_4_00010023_00000000_00000080
03_2_2_00010020_00000000_fffff281
03_2_2_00010021_00000000_ffffc3f2
03_2_2_00010022_00000000_ffff80c3
03_2_2_00010023_00000000_fffff281
03_2_5_00010021_00000000_0000c3f2
03_2_5_00010023_00000000_0000f281
04_3_3_00020004_00000000_00000000
04_1_0_00000000_00000000_00000000
04_1_0_00000000_00000000_00000000
04_4_3_00020004_00000000_00000003
04_4_3_00020004_00000000_00000004
05_5_6_00020000_000000a5_000000a5
05_5_8_00020000_1234563c_0000003c
06_1_8_00010030_01020304_00000000
06_6_8_00030000_ffffffff_00000000
06_1_8_0000fffc_ffffffff_00000000
06_1_8_00010400_ffffffff_00000000
06_6_6_00020001_000000ff_00000000
06_2_3_00010030_00000000_01020304
06_2_3_000103fc_00000000_deadbeef
06_2_3_00010000_00000000_11223344
00_0_0_00000000_00000000_00000000

//--- rv_lsu.f
verilog/lsu_pkg.sv
verilog/store_align.sv
verilog/byte_bank_ram.sv
verilog/load_return.sv
verilog/baud_timer.sv
verilog/uart_tx.sv
verilog/rv_lsu_top.sv
tb/tb_rv_lsu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_rv_lsu
FILELIST  ?= rv_lsu.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, output in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
